// File: vlog.f
rtl/iq_cfg_pkg.sv
rtl/iq_bus_pkg.sv
rtl/iq_operand_slot.sv
rtl/iq_control.sv
rtl/iq_issue_stage.sv
rtl/issue_queue.sv
verification/tb_issue_queue.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_issue_queue -Mdir obj_dir -f vlog.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_issue_queue > sim.log 2>&1

grep -qx "TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: verification/tb_issue_queue.sv
`timescale 1ns/1ps

module tb_issue_queue;
    import iq_cfg_pkg::*;
    import iq_bus_pkg::*;

    localparam int TAG_COUNT = 2**ROB_ID_W;
    localparam int RANDOM_CYCLES = 400;

    logic                              clk;
    logic                              reset_i;
    logic                              flush_i;
    logic                              dispatch_valid_i;
    dispatch_t                         dispatch_i;
    cdb_issue_info_t [CDB_COUNT-1:0]   cdb_i;
    wkup_tag_t [WAKEUP_SRC_CNT-1:0]    wkup_tag_i;
    word_t [WAKEUP_SRC_CNT-1:0]        wkup_data_i;
    logic                              iq_full_o;
    issue_t                            issue_o;

    // producer side, value of every broadcast tag
    word_t                      tag_val [TAG_COUNT];
    logic                       tag_busy [TAG_COUNT];
    rob_id_t                    produce_q [$];
    logic [WAKEUP_SRC_CNT-1:0]  promise_valid;
    word_t [WAKEUP_SRC_CNT-1:0] promise_data;

    // instructions in flight, by destination tag
    dispatch_t inflight [TAG_COUNT];
    logic      pending [TAG_COUNT];
    int        pending_cnt;
    rob_id_t   next_dest;

    integer seed;
    int     value_errs;
    int     other_errs;
    int     issued_cnt;

    issue_queue dut_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .cdb_i            (cdb_i),
        .wkup_tag_i       (wkup_tag_i),
        .wkup_data_i      (wkup_data_i),
        .iq_full_o        (iq_full_o),
        .issue_o          (issue_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ready sources keep their dispatch data, waiting ones take the producer value
    function automatic issue_t expected_issue(dispatch_t d);
        issue_t e;
        e.valid = 1'b1;
        e.dest_tag = d.dest_tag;
        for (int s = 0; s < SRC_COUNT; s++) begin
            e.operand[s] = d.src[s].ready ? d.src[s].data : tag_val[d.src[s].tag];
        end
        return e;
    endfunction

    function automatic src_info_t make_src(logic ready, rob_id_t tag, word_t data);
        src_info_t s;
        s.ready = ready;
        s.tag = tag;
        s.data = data;
        return s;
    endfunction

    task automatic check_issue(issue_t got, issue_t exp);
        if (got !== exp) begin
            $display("[ERROR] issue_o: got %h, expected %h (dest_tag %h)", got, exp, exp.dest_tag);
            value_errs++;
        end
    endtask

    task automatic check_full(logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] iq_full_o: got %h, expected %h", got, exp);
            value_errs++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        dispatch_valid_i = 1'b0;
        flush_i = 1'b0;
        for (int k = 0; k < CDB_COUNT; k++) begin
            cdb_i[k].valid = 1'b0;
        end
        for (int j = 0; j < WAKEUP_SRC_CNT; j++) begin
            wkup_tag_i[j].valid = 1'b0;
            // junk on idle lanes shows up any stale bypass
            wkup_data_i[j] = promise_valid[j] ? promise_data[j] : word_t'($random(seed));
        end
        promise_valid = '0;
    endtask

    task automatic send_dispatch(dispatch_t d);
        dispatch_valid_i = 1'b1;
        dispatch_i = d;
        inflight[d.dest_tag] = d;
        pending[d.dest_tag] = 1'b1;
        pending_cnt++;
    endtask

    task automatic send_cdb(int lane, rob_id_t tag, word_t data);
        cdb_i[lane].valid = 1'b1;
        cdb_i[lane].wreg_id = tag;
        cdb_i[lane].data = data;
        tag_val[tag] = data;
    endtask

    task automatic send_wakeup(int lane, rob_id_t tag, word_t data);
        wkup_tag_i[lane].valid = 1'b1;
        wkup_tag_i[lane].wreg_id = tag;
        promise_valid[lane] = 1'b1;
        promise_data[lane] = data;
        tag_val[tag] = data;
    endtask

    // flushed work is forgotten after the edge that drops it
    task automatic flush_queue();
        flush_i = 1'b1;
        @(posedge clk);
        for (int t = 0; t < TAG_COUNT; t++) begin
            pending[t] = 1'b0;
            tag_busy[t] = 1'b0;
        end
        pending_cnt = 0;
        produce_q.delete();
        next_cycle();
    endtask

    task automatic alloc_tag(output rob_id_t t);
        t = rob_id_t'($random(seed));
        for (int k = 0; k < TAG_COUNT && tag_busy[t]; k++) begin
            t = t + rob_id_t'(1);
        end
        tag_busy[t] = 1'b1;
        produce_q.push_back(t);
    endtask

    task automatic random_dispatch();
        dispatch_t d;
        rob_id_t   t;
        for (int k = 0; k < TAG_COUNT && pending[next_dest]; k++) begin
            next_dest = next_dest + rob_id_t'(1);
        end
        d.dest_tag = next_dest;
        next_dest = next_dest + rob_id_t'(1);
        for (int s = 0; s < SRC_COUNT; s++) begin
            if (($random(seed) & 3) == 0) begin
                d.src[s] = make_src(1'b1, '0, word_t'($random(seed)));
            end else begin
                alloc_tag(t);
                d.src[s] = make_src(1'b0, t, word_t'($random(seed)));
            end
        end
        send_dispatch(d);
    endtask

    task automatic produce_some();
        rob_id_t t;
        for (int k = 0; k < CDB_COUNT; k++) begin
            if (produce_q.size() > 0 && ($random(seed) & 3) == 0) begin
                t = produce_q.pop_front();
                send_cdb(k, t, word_t'($random(seed)));
            end
        end
        for (int j = 0; j < WAKEUP_SRC_CNT; j++) begin
            if (produce_q.size() > 0 && ($random(seed) & 3) == 0) begin
                t = produce_q.pop_front();
                send_wakeup(j, t, word_t'($random(seed)));
            end
        end
    endtask

    task automatic wait_idle(int max_cycles);
        int n;
        n = 0;
        while (pending_cnt > 0 && n < max_cycles) begin
            next_cycle();
            produce_some();
            n++;
        end
        if (pending_cnt > 0) begin
            $display("%0d instructions still waiting after %0d cycles", pending_cnt, max_cycles);
            other_errs++;
        end
    endtask

    task automatic wait_full(logic exp, int max_cycles);
        int n;
        n = 0;
        while (iq_full_o !== exp && n < max_cycles) begin
            next_cycle();
            n++;
        end
        check_full(iq_full_o, exp);
    endtask

    // issue checker
    initial begin
        rob_id_t t;
        forever begin
            @(negedge clk);
            if (!reset_i && issue_o.valid === 1'b1) begin
                t = issue_o.dest_tag;
                if (!pending[t]) begin
                    $display("unexpected issue of destination tag %0d", t);
                    other_errs++;
                end else begin
                    check_issue(issue_o, expected_issue(inflight[t]));
                    pending[t] = 1'b0;
                    pending_cnt--;
                    issued_cnt++;
                    for (int s = 0; s < SRC_COUNT; s++) begin
                        if (!inflight[t].src[s].ready) begin
                            tag_busy[inflight[t].src[s].tag] = 1'b0;
                        end
                    end
                end
            end
        end
    end

    initial begin
        dispatch_t d;
        seed = 3;
        reset_i = 1'b1;
        flush_i = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_i = '0;
        cdb_i = '0;
        wkup_tag_i = '0;
        wkup_data_i = '0;
        promise_valid = '0;
        promise_data = '0;
        for (int t = 0; t < TAG_COUNT; t++) begin
            tag_val[t] = '0;
            tag_busy[t] = 1'b0;
            pending[t] = 1'b0;
        end
        pending_cnt = 0;
        next_dest = '0;
        value_errs = 0;
        other_errs = 0;
        issued_cnt = 0;
        repeat (3) @(posedge clk);
        next_cycle();
        reset_i = 1'b0;
        check_full(iq_full_o, 1'b0);

        // both sources ready at dispatch
        d.dest_tag = 5'd1;
        d.src[0] = make_src(1'b1, '0, 32'h1111_0001);
        d.src[1] = make_src(1'b1, '0, 32'h2222_0001);
        send_dispatch(d);
        next_cycle();
        wait_idle(20);

        // both sources captured from the cdb, one per port
        d.dest_tag = 5'd2;
        d.src[0] = make_src(1'b0, 5'd10, 32'hdead_0010);
        d.src[1] = make_src(1'b0, 5'd11, 32'hdead_0011);
        send_dispatch(d);
        next_cycle();
        next_cycle();
        send_cdb(1, 5'd10, 32'h0a0a_1010);
        next_cycle();
        send_cdb(0, 5'd11, 32'h0b0b_1111);
        next_cycle();
        wait_idle(20);

        // back-to-back wakeup on lane 1
        d.dest_tag = 5'd3;
        d.src[0] = make_src(1'b0, 5'd12, 32'hdead_0012);
        d.src[1] = make_src(1'b1, '0, 32'h3333_0003);
        send_dispatch(d);
        next_cycle();
        next_cycle();
        send_wakeup(1, 5'd12, 32'hc0de_0012);
        next_cycle();
        wait_idle(20);

        // fill the queue with waiting work, then wake one
        for (int i = 0; i < IQ_DEPTH; i++) begin
            d.dest_tag = rob_id_t'(4 + i);
            d.src[0] = make_src(1'b0, rob_id_t'(16 + i), 32'hbad0_0000);
            d.src[1] = make_src(1'b1, '0, word_t'($random(seed)));
            check_full(iq_full_o, 1'b0);
            send_dispatch(d);
            next_cycle();
        end
        check_full(iq_full_o, 1'b1);
        send_cdb(0, 5'd18, 32'h0000_4418);
        next_cycle();
        wait_full(1'b0, 10);

        // refill the freed entry so the flush starts from a full queue
        d.dest_tag = 5'd8;
        d.src[0] = make_src(1'b0, 5'd18, 32'hbad0_0000);
        d.src[1] = make_src(1'b1, '0, word_t'($random(seed)));
        send_dispatch(d);
        next_cycle();
        check_full(iq_full_o, 1'b1);
        if (pending[6]) begin
            $display("woken instruction with destination tag 6 did not issue");
            other_errs++;
        end

        // flush the rest, late producers must wake nothing
        flush_queue();
        wait_full(1'b0, 5);
        for (int i = 0; i < IQ_DEPTH; i++) begin
            send_cdb(i % CDB_COUNT, rob_id_t'(16 + i), 32'hf1f1_0000);
            next_cycle();
        end
        d.dest_tag = 5'd9;
        d.src[0] = make_src(1'b1, '0, 32'h9999_0009);
        d.src[1] = make_src(1'b1, '0, 32'h9999_0019);
        send_dispatch(d);
        next_cycle();
        wait_idle(20);

        // mixed random traffic
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            next_cycle();
            if (($random(seed) & 63) == 0) begin
                flush_queue();
            end else begin
                if (!iq_full_o && ($random(seed) & 1) != 0) begin
                    random_dispatch();
                end
                produce_some();
            end
        end
        next_cycle();
        wait_idle(200);
        // a few idle cycles to catch a repeated issue
        for (int c = 0; c < 5; c++) begin
            next_cycle();
        end

        $display("errors: %0d value, %0d other; %0d instructions issued",
                 value_errs, other_errs, issued_cnt);
        if (value_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/issue_queue.sv
`timescale 1ns/1ps

module issue_queue (
    input  logic                                                          clk,
    input  logic                                                          reset_i,
    input  logic                                                          flush_i,
    input  logic                                                          dispatch_valid_i,
    input  iq_bus_pkg::dispatch_t                                         dispatch_i,
    input  iq_bus_pkg::cdb_issue_info_t [iq_cfg_pkg::CDB_COUNT-1:0]       cdb_i,
    input  iq_bus_pkg::wkup_tag_t [iq_cfg_pkg::WAKEUP_SRC_CNT-1:0]        wkup_tag_i,
    input  iq_cfg_pkg::word_t [iq_cfg_pkg::WAKEUP_SRC_CNT-1:0]            wkup_data_i,
    output logic                                                          iq_full_o,
    output iq_bus_pkg::issue_t                                            issue_o
);
    import iq_cfg_pkg::*;

    logic [IQ_DEPTH-1:0]                   alloc;
    logic [IQ_DEPTH-1:0]                   sel;
    logic [IQ_DEPTH-1:0]                   entry_valid;
    logic [IQ_DEPTH-1:0][SRC_COUNT-1:0]    src_ready;
    word_t [IQ_DEPTH-1:0][SRC_COUNT-1:0]   operand;
    logic                                  sel_valid;
    iq_idx_t                               sel_idx;
    rob_id_t [IQ_DEPTH-1:0]                dest_tag;

    iq_control u_control (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .src_ready_i      (src_ready),
        .alloc_o          (alloc),
        .sel_o            (sel),
        .entry_valid_o    (entry_valid),
        .sel_valid_o      (sel_valid),
        .sel_idx_o        (sel_idx),
        .dest_tag_o       (dest_tag),
        .iq_full_o        (iq_full_o)
    );

    // one slot per entry and source
    for (genvar e = 0; e < IQ_DEPTH; e++) begin : g_entry
        for (genvar s = 0; s < SRC_COUNT; s++) begin : g_src
            iq_operand_slot u_slot (
                .clk           (clk),
                .reset_i       (reset_i),
                .flush_i       (flush_i),
                .alloc_i       (alloc[e]),
                .sel_i         (sel[e]),
                .entry_valid_i (entry_valid[e]),
                .src_i         (dispatch_i.src[s]),
                .cdb_i         (cdb_i),
                .wkup_tag_i    (wkup_tag_i),
                .wkup_data_i   (wkup_data_i),
                .ready_o       (src_ready[e][s]),
                .data_o        (operand[e][s])
            );
        end
    end

    iq_issue_stage u_issue (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .sel_valid_i (sel_valid),
        .sel_idx_i   (sel_idx),
        .dest_tag_i  (dest_tag),
        .operand_i   (operand),
        .issue_o     (issue_o)
    );

endmodule

// File: rtl/iq_issue_stage.sv
`timescale 1ns/1ps

module iq_issue_stage (
    input  logic                                                                 clk,
    input  logic                                                                 reset_i,
    input  logic                                                                 flush_i,
    input  logic                                                                 sel_valid_i,
    input  iq_cfg_pkg::iq_idx_t                                                  sel_idx_i,
    input  iq_cfg_pkg::rob_id_t [iq_cfg_pkg::IQ_DEPTH-1:0]                       dest_tag_i,
    input  iq_cfg_pkg::word_t [iq_cfg_pkg::IQ_DEPTH-1:0][iq_cfg_pkg::SRC_COUNT-1:0] operand_i,
    output iq_bus_pkg::issue_t                                                   issue_o
);
    import iq_cfg_pkg::*;

    logic                  valid_q;
    rob_id_t               dest_tag_q;
    word_t [SRC_COUNT-1:0] operand_q;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sel_valid_i;
        end
    end

    // payload only moves on a real select
    always_ff @(posedge clk) begin
        if (sel_valid_i) begin
            dest_tag_q <= dest_tag_i[sel_idx_i];
            operand_q <= operand_i[sel_idx_i];
        end
    end

    assign issue_o.valid = valid_q;
    assign issue_o.dest_tag = dest_tag_q;
    assign issue_o.operand = operand_q;

endmodule

// File: rtl/iq_control.sv
`timescale 1ns/1ps

module iq_control (
    input  logic                                                           clk,
    input  logic                                                           reset_i,
    input  logic                                                           flush_i,
    input  logic                                                           dispatch_valid_i,
    input  iq_bus_pkg::dispatch_t                                          dispatch_i,
    input  logic [iq_cfg_pkg::IQ_DEPTH-1:0][iq_cfg_pkg::SRC_COUNT-1:0]     src_ready_i,
    output logic [iq_cfg_pkg::IQ_DEPTH-1:0]                                alloc_o,
    output logic [iq_cfg_pkg::IQ_DEPTH-1:0]                                sel_o,
    output logic [iq_cfg_pkg::IQ_DEPTH-1:0]                                entry_valid_o,
    output logic                                                           sel_valid_o,
    output iq_cfg_pkg::iq_idx_t                                            sel_idx_o,
    output iq_cfg_pkg::rob_id_t [iq_cfg_pkg::IQ_DEPTH-1:0]                 dest_tag_o,
    output logic                                                           iq_full_o
);
    import iq_cfg_pkg::*;

    typedef enum logic {
        ST_RUN,
        ST_FLUSHING
    } state_e;

    state_e                    state_q;
    state_e                    state_d;
    logic [IQ_DEPTH-1:0]       valid_q;
    logic [IQ_DEPTH-1:0]       valid_d;
    logic [IQ_DEPTH-1:0]       entry_ready;
    rob_id_t [IQ_DEPTH-1:0]    dest_tag_q;
    logic                      full_q;
    logic                      free_found;
    iq_idx_t                   free_idx;
    logic                      accept;

    always_comb begin
        case (state_q)
            ST_RUN:      state_d = flush_i ? ST_FLUSHING : ST_RUN;
            ST_FLUSHING: state_d = flush_i ? ST_FLUSHING : ST_RUN;
            default:     state_d = ST_RUN;
        endcase
    end

    // lowest ready entry wins, scan from the top
    always_comb begin
        sel_valid_o = 1'b0;
        sel_idx_o = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            entry_ready[i] = valid_q[i] && (&src_ready_i[i]);
            if (entry_ready[i] && !flush_i) begin
                sel_valid_o = 1'b1;
                sel_idx_o = iq_idx_t'(i);
            end
        end
    end

    always_comb begin
        free_found = 1'b0;
        free_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_found = 1'b1;
                free_idx = iq_idx_t'(i);
            end
        end
    end

    // no dispatch during a flush or the quiet cycle after it
    assign accept = dispatch_valid_i && free_found && !flush_i && (state_q == ST_RUN);

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            alloc_o[i] = accept && (free_idx == iq_idx_t'(i));
            sel_o[i] = sel_valid_o && (sel_idx_o == iq_idx_t'(i));
        end
    end

    assign valid_d = flush_i ? '0 : ((valid_q & ~sel_o) | alloc_o);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_RUN;
            valid_q <= '0;
            full_q <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_q <= valid_d;
            // quiet cycle after flush reads as full
            full_q <= (state_d == ST_FLUSHING) || (&valid_d);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dest_tag_q[free_idx] <= dispatch_i.dest_tag;
        end
    end

    assign entry_valid_o = valid_q;
    assign dest_tag_o = dest_tag_q;
    assign iq_full_o = full_q;

    a_no_dispatch_full: assert property (@(posedge clk) disable iff (reset_i)
        dispatch_valid_i |-> !iq_full_o)
        else $error("dispatch while the queue is full");

    a_sel_legal: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(sel_o) && ((sel_o & ~valid_q) == '0))
        else $error("issue select %b not a single valid entry", sel_o);

endmodule

// File: rtl/iq_operand_slot.sv
`timescale 1ns/1ps

module iq_operand_slot (
    input  logic                                                     clk,
    input  logic                                                     reset_i,
    input  logic                                                     flush_i,
    input  logic                                                     alloc_i,
    input  logic                                                     sel_i,
    input  logic                                                     entry_valid_i,
    input  iq_bus_pkg::src_info_t                                    src_i,
    input  iq_bus_pkg::cdb_issue_info_t [iq_cfg_pkg::CDB_COUNT-1:0]  cdb_i,
    input  iq_bus_pkg::wkup_tag_t [iq_cfg_pkg::WAKEUP_SRC_CNT-1:0]   wkup_tag_i,
    input  iq_cfg_pkg::word_t [iq_cfg_pkg::WAKEUP_SRC_CNT-1:0]       wkup_data_i,
    output logic                                                     ready_o,
    output iq_cfg_pkg::word_t                                        data_o
);
    import iq_cfg_pkg::*;

    word_t                     data_q;
    rob_id_t                   tag_q;
    logic                      ready_q;
    logic [WAKEUP_SRC_CNT-1:0] wkup_sel_q;

    rob_id_t                   cur_tag;
    logic                      waiting;
    logic [CDB_COUNT-1:0]      cdb_hit;
    logic                      cdb_capture;
    word_t                     cdb_result;
    logic [WAKEUP_SRC_CNT-1:0] wkup_hit;
    word_t                     wkup_result;

    // a dispatching source snoops with its incoming tag
    assign cur_tag = alloc_i ? src_i.tag : tag_q;
    assign waiting = alloc_i ? !src_i.ready : (entry_valid_i && !ready_q);

    always_comb begin
        cdb_result = '0;
        for (int i = 0; i < CDB_COUNT; i++) begin
            cdb_hit[i] = waiting && cdb_i[i].valid && (cdb_i[i].wreg_id == cur_tag);
            cdb_result |= cdb_hit[i] ? cdb_i[i].data : '0;
        end
    end

    assign cdb_capture = |cdb_hit;

    // cdb data in hand beats a wakeup promise
    always_comb begin
        for (int j = 0; j < WAKEUP_SRC_CNT; j++) begin
            wkup_hit[j] = waiting && !cdb_capture && wkup_tag_i[j].valid &&
                          (wkup_tag_i[j].wreg_id == cur_tag);
        end
    end

    always_comb begin
        wkup_result = '0;
        for (int j = 0; j < WAKEUP_SRC_CNT; j++) begin
            wkup_result |= wkup_sel_q[j] ? wkup_data_i[j] : '0;
        end
    end

    // bypass lane while a wakeup is pending
    assign data_o = (|wkup_sel_q) ? wkup_result : data_q;
    assign ready_o = ready_q;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ready_q <= 1'b0;
        end else if (alloc_i) begin
            ready_q <= src_i.ready || cdb_capture || (|wkup_hit);
        end else if (sel_i) begin
            ready_q <= 1'b0;
        end else if (cdb_capture || (|wkup_hit)) begin
            ready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i || sel_i) begin
            wkup_sel_q <= '0;
        end else begin
            wkup_sel_q <= wkup_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            tag_q <= src_i.tag;
        end
        if (cdb_capture) begin
            data_q <= cdb_result;
        end else if (alloc_i) begin
            data_q <= src_i.data;
        end else if (|wkup_sel_q) begin
            // keep the bypassed value once the lane moves on
            data_q <= wkup_result;
        end
    end

    // one producer per tag, so two ports never hit together
    a_cdb_single_hit: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(cdb_hit))
        else $error("several CDB ports match tag %0d", cur_tag);

    a_alloc_sel_excl: assert property (@(posedge clk) disable iff (reset_i)
        !(alloc_i && sel_i))
        else $error("slot written and issued in the same cycle");

endmodule

// File: rtl/iq_bus_pkg.sv
package iq_bus_pkg;

    import iq_cfg_pkg::*;

    // one source as seen at dispatch
    typedef struct packed {
        logic    ready;
        rob_id_t tag;
        word_t   data;
    } src_info_t;

    typedef struct packed {
        rob_id_t                   dest_tag;
        src_info_t [SRC_COUNT-1:0] src;
    } dispatch_t;

    // result broadcast
    typedef struct packed {
        logic    valid;
        rob_id_t wreg_id;
        word_t   data;
    } cdb_issue_info_t;

    // early wakeup, data follows a cycle later on the same lane
    typedef struct packed {
        logic    valid;
        rob_id_t wreg_id;
    } wkup_tag_t;

    typedef struct packed {
        logic                  valid;
        rob_id_t               dest_tag;
        word_t [SRC_COUNT-1:0] operand;
    } issue_t;

endpackage

// File: rtl/iq_cfg_pkg.sv
package iq_cfg_pkg;

    // queue geometry
    localparam int IQ_DEPTH = 4;
    localparam int SRC_COUNT = 2;

    // result broadcast and early wakeup lanes
    localparam int CDB_COUNT = 2;
    localparam int WAKEUP_SRC_CNT = 2;

    // field widths
    localparam int ROB_ID_W = 5;
    localparam int WORD_W = 32;
    localparam int IQ_IDX_W = $clog2(IQ_DEPTH);

    // operand value
    typedef logic [WORD_W-1:0] word_t;

    // producer tag, names a ROB slot
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // queue entry number
    typedef logic [IQ_IDX_W-1:0] iq_idx_t;

endpackage
